// ==== Bender.yml ====
package:
  name: mem_wb

sources:
  - rtl/rv_isa_pkg.sv
  - rtl/pipe_pkg.sv
  - rtl/dmem_if.sv
  - rtl/mem_access.sv
  - rtl/data_mem.sv
  - rtl/csr_unit.sv
  - rtl/wb_select.sv
  - rtl/mem_wb_top.sv
  - target: test
    files:
      - tb/tb_mem_wb_top.sv

// ==== flist.f ====
rtl/rv_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/dmem_if.sv
rtl/mem_access.sv
rtl/data_mem.sv
rtl/csr_unit.sv
rtl/wb_select.sv
rtl/mem_wb_top.sv
tb/tb_mem_wb_top.sv

// ==== rtl/csr_unit.sv ====
`default_nettype none

module csr_unit
    import rv_isa_pkg::*, pipe_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            keep,
    input  wire logic            nop,
    input  wire logic            csr_we,
    input  csr_addr_t            csr_addr,
    input  wire logic [xlen-1:0] csr_wdata,
    output logic [xlen-1:0]      csr_old_q
);

    logic [xlen-1:0] mscratch;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    logic [xlen-1:0] csr_old;

    // value before this cycle's write
    always_comb begin
        case (csr_addr)
            csr_mscratch: csr_old = mscratch;
            csr_mtvec:    csr_old = mtvec;
            csr_mepc:     csr_old = mepc;
            csr_mcause:   csr_old = mcause;
            default:      csr_old = '0;   // unimplemented reads zero
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mscratch <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (csr_we) begin
            case (csr_addr)
                csr_mscratch: mscratch <= csr_wdata;
                csr_mtvec:    mtvec    <= csr_wdata;
                csr_mepc:     mepc     <= csr_wdata;
                csr_mcause:   mcause   <= csr_wdata;
                default:      ;
            endcase
        end
    end

    // stage register for the read side, same rule as mem_access
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            csr_old_q <= '0;
        end else if (keep) begin
            csr_old_q <= csr_old_q;
        end else if (nop) begin
            csr_old_q <= '0;
        end else begin
            csr_old_q <= csr_old;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/data_mem.sv ====
`default_nettype none

module data_mem
    import rv_isa_pkg::*, pipe_pkg::*;
(
    input wire logic clk,
    dmem_if.slave    bus
);

    logic [xlen-1:0]    mem [dmem_words];
    logic [dmem_aw-1:0] word_idx;
    logic [xbytes-1:0]  be_base;
    logic [xbytes-1:0]  be;
    logic [xlen-1:0]    wdata_lane;

    assign word_idx = bus.daddr[dmem_aw+1:2];

    always_comb begin
        case (bus.dsize)
            dsize_byte: be_base = 4'b0001;
            dsize_half: be_base = 4'b0011;
            default:    be_base = 4'b1111;
        endcase
    end

    // move the store data and lanes up to the addressed byte
    assign be         = be_base << bus.daddr[1:0];
    assign wdata_lane = bus.wdata << {bus.daddr[1:0], 3'b000};

    always_ff @(posedge clk) begin
        if (bus.dreq && bus.dwrite) begin
            for (int i = 0; i < xbytes; i++) begin
                if (be[i]) begin
                    mem[word_idx][i*8 +: 8] <= wdata_lane[i*8 +: 8];
                end
            end
        end
    end

    assign bus.rdata = mem[word_idx];   // whole word, aligned in mem_access

    // the lane logic has no wrap, so misaligned accesses would split a halfword
    a_half_aligned: assert property (
        @(posedge clk)
        bus.dreq && bus.dsize == dsize_half |-> bus.daddr[0] == 1'b0
    );

    a_word_aligned: assert property (
        @(posedge clk)
        bus.dreq && bus.dsize == dsize_word |-> bus.daddr[1:0] == 2'b00
    );

endmodule

`default_nettype wire

// ==== rtl/dmem_if.sv ====
`default_nettype none

interface dmem_if
    import rv_isa_pkg::*, pipe_pkg::*;
();

    logic [xlen-1:0] daddr;
    logic            dreq;     // one-cycle strobe
    logic            dwrite;
    dsize_t          dsize;
    logic [xlen-1:0] wdata;    // store data, low bits
    logic [xlen-1:0] rdata;    // whole word, same cycle

    modport master (
        output daddr,
        output dreq,
        output dwrite,
        output dsize,
        output wdata,
        input  rdata
    );

    modport slave (
        input  daddr,
        input  dreq,
        input  dwrite,
        input  dsize,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// ==== rtl/mem_access.sv ====
`default_nettype none

module mem_access
    import rv_isa_pkg::*, pipe_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  keep,
    input  wire logic                  nop,
    input  wb_ctrl_t                   wb_ctrl_in,
    input  mem_op_t                    mem_op,
    input  wire logic [xlen-1:0]       pc_plus4,
    input  wire logic [xlen-1:0]       alu_result,
    input  wire logic [xlen-1:0]       store_data,
    input  wire logic [reg_addr_w-1:0] rd_in,
    input  funct3_t                    funct3,
    input  dsize_t                     dsize,
    input  fwd_tag_t                   fwd_tag_in,
    output wb_ctrl_t                   wb_ctrl_out,
    output logic [reg_addr_w-1:0]      rd_out,
    output logic [xlen-1:0]            alu_result_q,
    output logic [xlen-1:0]            pc_plus4_q,
    output logic [xlen-1:0]            load_data_q,
    output fwd_tag_t                   fwd_tag_out,
    dmem_if.master                     dbus
);

    logic [xlen-1:0] rdata_shift;
    logic [xlen-1:0] load_ext;

    // the memory answers in this same cycle
    assign dbus.dreq   = |mem_op;
    assign dbus.dwrite = mem_op[0];
    assign dbus.daddr  = alu_result;
    assign dbus.dsize  = dsize;
    assign dbus.wdata  = store_data;

    assign rdata_shift = dbus.rdata >> {alu_result[1:0], 3'b000};   // wanted lane to bit 0

    always_comb begin
        load_ext = '0;
        if (mem_op == mem_load) begin
            case (funct3)
                f3_lb:   load_ext = {{(xlen-8){rdata_shift[7]}}, rdata_shift[7:0]};
                f3_lh:   load_ext = {{(xlen-16){rdata_shift[15]}}, rdata_shift[15:0]};
                f3_lw:   load_ext = rdata_shift;
                f3_lbu:  load_ext = {{(xlen-8){1'b0}}, rdata_shift[7:0]};
                f3_lhu:  load_ext = {{(xlen-16){1'b0}}, rdata_shift[15:0]};
                default: load_ext = '0;
            endcase
        end
    end

    // keep wins over nop
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wb_ctrl_out  <= '0;
            rd_out       <= '0;
            alu_result_q <= '0;
            pc_plus4_q   <= '0;
            load_data_q  <= '0;
            fwd_tag_out  <= '0;
        end else if (keep) begin
            wb_ctrl_out  <= wb_ctrl_out;
            rd_out       <= rd_out;
            alu_result_q <= alu_result_q;
            pc_plus4_q   <= pc_plus4_q;
            load_data_q  <= load_data_q;
            fwd_tag_out  <= fwd_tag_out;
        end else if (nop) begin
            wb_ctrl_out  <= '0;     // bubble
            rd_out       <= '0;
            alu_result_q <= '0;
            pc_plus4_q   <= '0;
            load_data_q  <= '0;
            fwd_tag_out  <= '0;
        end else begin
            wb_ctrl_out  <= wb_ctrl_in;
            rd_out       <= rd_in;
            alu_result_q <= alu_result;
            pc_plus4_q   <= pc_plus4;
            load_data_q  <= load_ext;
            fwd_tag_out  <= fwd_tag_in;
        end
    end

    // a write strobe on the bus only comes from a real store
    a_write_is_store: assert property (
        @(posedge clk) disable iff (!rst)
        dbus.dreq && dbus.dwrite |-> mem_op == mem_store
    );

    // upstream decode never hands over a reserved load width
    a_load_funct3: assert property (
        @(posedge clk) disable iff (!rst)
        mem_op == mem_load |-> funct3 inside {f3_lb, f3_lh, f3_lw, f3_lbu, f3_lhu}
    );

endmodule

`default_nettype wire

// ==== rtl/mem_wb_top.sv ====
`default_nettype none

module mem_wb_top
    import rv_isa_pkg::*, pipe_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  keep,
    input  wire logic                  nop,
    input  wb_ctrl_t                   wb_ctrl_in,
    input  mem_op_t                    mem_op,
    input  wire logic [xlen-1:0]       pc_plus4,
    input  wire logic [xlen-1:0]       alu_result,
    input  wire logic [xlen-1:0]       store_data,
    input  wire logic [reg_addr_w-1:0] rd_in,
    input  funct3_t                    funct3,
    input  dsize_t                     dsize,
    input  fwd_tag_t                   fwd_tag_in,
    input  wire logic                  csr_we,
    input  csr_addr_t                  csr_addr,
    input  wire logic [xlen-1:0]       csr_wdata,
    output logic                       wb_en,
    output logic [reg_addr_w-1:0]      wb_rd,
    output logic [xlen-1:0]            wb_data,
    output fwd_tag_t                   fwd_tag_out
);

    wb_ctrl_t              wb_ctrl_q;
    logic [reg_addr_w-1:0] rd_q;
    logic [xlen-1:0]       alu_result_q;
    logic [xlen-1:0]       pc_plus4_q;
    logic [xlen-1:0]       load_data_q;
    logic [xlen-1:0]       csr_old_q;

    dmem_if dbus ();

    mem_access u_mem_access (
        .clk          (clk),
        .rst          (rst),
        .keep         (keep),
        .nop          (nop),
        .wb_ctrl_in   (wb_ctrl_in),
        .mem_op       (mem_op),
        .pc_plus4     (pc_plus4),
        .alu_result   (alu_result),
        .store_data   (store_data),
        .rd_in        (rd_in),
        .funct3       (funct3),
        .dsize        (dsize),
        .fwd_tag_in   (fwd_tag_in),
        .wb_ctrl_out  (wb_ctrl_q),
        .rd_out       (rd_q),
        .alu_result_q (alu_result_q),
        .pc_plus4_q   (pc_plus4_q),
        .load_data_q  (load_data_q),
        .fwd_tag_out  (fwd_tag_out),
        .dbus         (dbus)
    );

    data_mem u_data_mem (
        .clk (clk),
        .bus (dbus)
    );

    // runs beside the data access, same stage timing
    csr_unit u_csr_unit (
        .clk       (clk),
        .rst       (rst),
        .keep      (keep),
        .nop       (nop),
        .csr_we    (csr_we),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .csr_old_q (csr_old_q)
    );

    wb_select u_wb_select (
        .wb_ctrl    (wb_ctrl_q),
        .rd         (rd_q),
        .alu_result (alu_result_q),
        .pc_plus4   (pc_plus4_q),
        .load_data  (load_data_q),
        .csr_old    (csr_old_q),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

// ==== rtl/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    localparam int xlen       = 32;
    localparam int xbytes     = xlen / 8;        // byte lanes per word
    localparam int reg_addr_w = 5;
    localparam int dmem_words = 256;
    localparam int dmem_aw    = $clog2(dmem_words);

    // where the writeback value comes from
    typedef enum logic [1:0] {
        src_alu = 2'b00,
        src_mem = 2'b01,
        src_pc4 = 2'b10,
        src_csr = 2'b11
    } wb_src_t;

    // reg_we lands on bit 2, src on bits 1:0
    typedef struct packed {
        logic    reg_we;
        wb_src_t src;
    } wb_ctrl_t;

    typedef logic [1:0] fwd_tag_t;   // forwarding/stall tag, passed through

endpackage

`default_nettype wire

// ==== rtl/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    // load width codes from the funct3 field
    typedef enum logic [2:0] {
        f3_lb  = 3'b000,
        f3_lh  = 3'b001,
        f3_lw  = 3'b010,
        f3_lbu = 3'b100,
        f3_lhu = 3'b101
    } funct3_t;

    // bit 0 marks a store, bit 1 a load
    typedef enum logic [1:0] {
        mem_none  = 2'b00,
        mem_store = 2'b01,
        mem_load  = 2'b10
    } mem_op_t;

    typedef enum logic [1:0] {
        dsize_byte = 2'b00,
        dsize_half = 2'b01,
        dsize_word = 2'b10
    } dsize_t;

    typedef logic [11:0] csr_addr_t;

    // machine-mode CSRs that exist in this core
    localparam csr_addr_t csr_mscratch = 12'h340;
    localparam csr_addr_t csr_mtvec    = 12'h305;
    localparam csr_addr_t csr_mepc     = 12'h341;
    localparam csr_addr_t csr_mcause   = 12'h342;

endpackage

`default_nettype wire

// ==== rtl/wb_select.sv ====
`default_nettype none

module wb_select
    import pipe_pkg::*;
(
    input  wb_ctrl_t                   wb_ctrl,
    input  wire logic [reg_addr_w-1:0] rd,
    input  wire logic [xlen-1:0]       alu_result,
    input  wire logic [xlen-1:0]       pc_plus4,
    input  wire logic [xlen-1:0]       load_data,
    input  wire logic [xlen-1:0]       csr_old,
    output logic                       wb_en,
    output logic [reg_addr_w-1:0]      wb_rd,
    output logic [xlen-1:0]            wb_data
);

    assign wb_en = wb_ctrl.reg_we && (rd != '0);   // x0 stays zero
    assign wb_rd = rd;

    always_comb begin
        case (wb_ctrl.src)
            src_alu: wb_data = alu_result;
            src_mem: wb_data = load_data;
            src_pc4: wb_data = pc_plus4;    // jal/jalr link
            src_csr: wb_data = csr_old;
            default: wb_data = alu_result;
        endcase
    end

endmodule

`default_nettype wire

// ==== tb/tb_mem_wb_top.sv ====
`default_nettype none

module tb_mem_wb_top
    import rv_isa_pkg::*, pipe_pkg::*;
();

    logic                  clk;
    logic                  rst;
    logic                  keep;
    logic                  nop;
    wb_ctrl_t              wb_ctrl_in;
    mem_op_t               mem_op;
    logic [xlen-1:0]       pc_plus4;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       store_data;
    logic [reg_addr_w-1:0] rd_in;
    funct3_t               funct3;
    dsize_t                dsize;
    fwd_tag_t              fwd_tag_in;
    logic                  csr_we;
    csr_addr_t             csr_addr;
    logic [xlen-1:0]       csr_wdata;
    logic                  wb_en;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;
    fwd_tag_t              fwd_tag_out;

    integer seed       = 32'h1cde;
    int     n_checks   = 0;
    int     n_errors   = 0;
    int     n_timeouts = 0;

    mem_wb_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                         input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic drive_idle();
        keep       = 1'b0;
        nop        = 1'b0;
        wb_ctrl_in = '0;
        mem_op     = mem_none;
        pc_plus4   = '0;
        alu_result = '0;
        store_data = '0;
        rd_in      = '0;
        funct3     = f3_lw;
        dsize      = dsize_word;
        fwd_tag_in = '0;
        csr_we     = 1'b0;
        csr_addr   = '0;
        csr_wdata  = '0;
    endtask

    // result should show up one edge after the inputs
    task automatic wait_writeback(input string what);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!wb_en && cycles < 8);
        if (!wb_en) begin
            n_timeouts++;
            $display("%s: no register write seen within 8 cycles", what);
        end
        check(cycles, 1, {what, " latency"});
    endtask

    // reference extension from the stored word and the load rules
    function automatic logic [xlen-1:0] expect_load(input logic [xlen-1:0] word,
                                                    input int offset, input funct3_t f3);
        logic signed [7:0]  sbyte;
        logic signed [15:0] shalf;
        logic [xlen-1:0]    ext;
        sbyte = word[8*offset +: 8];
        shalf = word[16*(offset/2) +: 16];
        case (f3)
            f3_lb:   ext = sbyte;
            f3_lh:   ext = shalf;
            f3_lw:   ext = word;
            f3_lbu:  ext = word[8*offset +: 8];
            f3_lhu:  ext = word[16*(offset/2) +: 16];
            default: ext = '0;
        endcase
        return ext;
    endfunction

    task automatic store_to_mem(input logic [xlen-1:0] addr, input logic [xlen-1:0] data,
                                input dsize_t size);
        drive_idle();
        mem_op     = mem_store;
        alu_result = addr;
        store_data = data;
        dsize      = size;
        @(negedge clk);
        check(wb_en, 0, "store wb_en");
        drive_idle();
    endtask

    task automatic load_and_check(input logic [xlen-1:0] addr, input funct3_t f3,
                                  input logic [xlen-1:0] exp, input string what);
        drive_idle();
        @(negedge clk);   // wb_en low before the load
        mem_op = mem_load;
        funct3 = f3;
        case (f3)
            f3_lw:         dsize = dsize_word;
            f3_lh, f3_lhu: dsize = dsize_half;
            default:       dsize = dsize_byte;
        endcase
        alu_result = addr;
        rd_in      = 5'd10;
        wb_ctrl_in = '{reg_we: 1'b1, src: src_mem};
        fwd_tag_in = 2'b01;
        wait_writeback(what);
        check(wb_rd, 10, {what, " rd"});
        check(wb_data, exp, what);
        check(fwd_tag_out, 2'b01, {what, " tag"});
        drive_idle();
    endtask

    task automatic csr_access(input csr_addr_t addr, input logic we,
                              input logic [xlen-1:0] wdata, input logic [xlen-1:0] exp_old,
                              input string what);
        drive_idle();
        @(negedge clk);
        csr_we     = we;
        csr_addr   = addr;
        csr_wdata  = wdata;
        rd_in      = 5'd12;
        wb_ctrl_in = '{reg_we: 1'b1, src: src_csr};
        wait_writeback(what);
        check(wb_data, exp_old, what);
        drive_idle();
    endtask

    task automatic reset_values();
        check(wb_en, 0, "wb_en after reset");
        check(fwd_tag_out, 0, "fwd_tag_out after reset");
        check(wb_data, 0, "wb_data after reset");
    endtask

    task automatic loads_after_stores();
        logic [xlen-1:0] word;
        logic [xlen-1:0] model;
        logic [xlen-1:0] data;
        word = $random(seed);
        store_to_mem(32'h40, word, dsize_word);
        for (int off = 0; off < 4; off++) begin
            load_and_check(32'h40 + off, f3_lb, expect_load(word, off, f3_lb),
                           $sformatf("lb +%0d", off));
            load_and_check(32'h40 + off, f3_lbu, expect_load(word, off, f3_lbu),
                           $sformatf("lbu +%0d", off));
        end
        for (int off = 0; off < 4; off += 2) begin
            load_and_check(32'h40 + off, f3_lh, expect_load(word, off, f3_lh),
                           $sformatf("lh +%0d", off));
            load_and_check(32'h40 + off, f3_lhu, expect_load(word, off, f3_lhu),
                           $sformatf("lhu +%0d", off));
        end
        load_and_check(32'h40, f3_lw, word, "lw");

        // narrow stores touch only their own lanes
        model = $random(seed);
        store_to_mem(32'h80, model, dsize_word);
        data = $random(seed);
        store_to_mem(32'h81, data, dsize_byte);
        model[15:8] = data[7:0];
        data = $random(seed);
        store_to_mem(32'h82, data, dsize_half);
        model[31:16] = data[15:0];
        load_and_check(32'h80, f3_lw, model, "lw after byte and half stores");
    endtask

    task automatic csr_read_modify_write();
        csr_access(csr_mscratch, 1'b1, 32'hcafe_0001, 32'h0, "mscratch first rmw");
        csr_access(csr_mscratch, 1'b1, 32'hcafe_0002, 32'hcafe_0001, "mscratch second rmw");
        csr_access(csr_mtvec, 1'b1, 32'h0000_0100, 32'h0, "mtvec rmw");
        csr_access(csr_mcause, 1'b1, 32'h8000_0007, 32'h0, "mcause rmw");
        csr_access(csr_mepc, 1'b1, 32'h0000_0420, 32'h0, "mepc rmw");
        csr_access(csr_mscratch, 1'b0, 32'h0, 32'hcafe_0002, "mscratch read");
        csr_access(csr_mepc, 1'b0, 32'h0, 32'h0000_0420, "mepc read");
        csr_access(12'h7c0, 1'b1, 32'hdead_beef, 32'h0, "unimplemented write");
        csr_access(12'h7c0, 1'b0, 32'h0, 32'h0, "unimplemented read");
    endtask

    task automatic writeback_sources();
        drive_idle();
        @(negedge clk);
        wb_ctrl_in = '{reg_we: 1'b1, src: src_alu};
        rd_in      = 5'd3;
        alu_result = 32'h1234_5678;
        pc_plus4   = 32'h0000_0104;
        wait_writeback("alu source");
        check(wb_rd, 3, "alu source rd");
        check(wb_data, 32'h1234_5678, "alu source data");
        drive_idle();
        @(negedge clk);
        wb_ctrl_in = '{reg_we: 1'b1, src: src_pc4};
        rd_in      = 5'd1;
        alu_result = 32'h1234_5678;
        pc_plus4   = 32'h0000_0104;
        wait_writeback("pc4 source");
        check(wb_data, 32'h0000_0104, "pc4 source data");
        wb_ctrl_in = '{reg_we: 1'b1, src: src_alu};
        rd_in      = 5'd0;   // x0
        @(negedge clk);
        check(wb_en, 0, "x0 write suppressed");
        drive_idle();
    endtask

    task automatic keep_and_nop();
        drive_idle();
        wb_ctrl_in = '{reg_we: 1'b1, src: src_alu};
        rd_in      = 5'd9;
        alu_result = 32'h0bad_f00d;
        fwd_tag_in = 2'b10;
        wait_writeback("keep setup");
        drive_idle();
        keep       = 1'b1;
        wb_ctrl_in = '{reg_we: 1'b1, src: src_pc4};   // must not get through
        rd_in      = 5'd4;
        pc_plus4   = 32'h0000_0200;
        fwd_tag_in = 2'b11;
        for (int i = 0; i < 4; i++) begin
            if (i == 3) begin
                nop = 1'b1;   // keep still wins
            end
            @(negedge clk);
            check(wb_en, 1, $sformatf("keep cycle %0d wb_en", i));
            check(wb_rd, 9, $sformatf("keep cycle %0d rd", i));
            check(wb_data, 32'h0bad_f00d, $sformatf("keep cycle %0d data", i));
            check(fwd_tag_out, 2'b10, $sformatf("keep cycle %0d tag", i));
        end
        keep = 1'b0;
        @(negedge clk);
        check(wb_en, 0, "nop wb_en");
        check(fwd_tag_out, 0, "nop tag");
        drive_idle();
    endtask

    initial begin
        drive_idle();
        rst = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        reset_values();
        loads_after_stores();
        csr_read_modify_write();
        writeback_sources();
        keep_and_nop();
        @(negedge clk);
        $display("checks: %0d, value errors: %0d, timeouts: %0d",
                 n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
